/* files.f */
design/rx_ingress_pkg.sv
design/rx_frame_writer.sv
design/rx_frame_buffer.sv
design/rx_frame_reader.sv
design/rx_ingress_top.sv
bench/rx_ingress_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the rx ingress testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f files.f --top-module rx_ingress_tb -o rx_ingress_sim \
   && ./obj_dir/rx_ingress_sim > sim.log 2>&1 \
   || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Simulation completed successfully$" sim.log \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

/* bench/rx_ingress_tb.sv */
// testbench for the rx ingress path with frame stimulus, scoreboard, credit and pause checks
`timescale 1ns/1ps
`default_nettype none

module rx_ingress_tb
   import rx_ingress_pkg::*;
();

   localparam int N_PASS = 20;
   localparam int N_ERR  = 20;
   localparam int N_FULL = 12;
   // 200 cycles per frame plus a fixed margin
   localparam int TIMEOUT_CYCLES = (N_PASS + N_ERR + N_FULL) * 200 + 2000;

   logic        rx_clk;
   logic        sys_rst;
   beat_data_t  tdata;
   beat_keep_t  tkeep;
   logic        tlast;
   logic        tuser;
   logic        tvalid;
   logic        pause_req;
   beat_data_t  out_data;
   beat_keep_t  out_keep;
   logic        out_last;
   logic        out_valid;
   logic        out_credit;

   integer      seed;
   // beat on the bus belongs to a kept good frame
   logic        tracked;
   logic        credit_on;
   int          frames_dropped;
   // reference model
   data_entry_t exp_q[$];
   data_entry_t exp_beat;
   int          occ_pred;
   int          prev_pred;
   logic        kept_d1;
   logic        kept_d2;
   int          beats_out;
   int          credits_seen;
   int          credits_sent;
   int          since_rst;

   rx_ingress_top dut0 (
      .rx_clk             (rx_clk),
      .sys_rst            (sys_rst),
      .rx_axis_mac_tdata  (tdata),
      .rx_axis_mac_tkeep  (tkeep),
      .rx_axis_mac_tlast  (tlast),
      .rx_axis_mac_tuser  (tuser),
      .rx_axis_mac_tvalid (tvalid),
      .pause_req          (pause_req),
      .out_data           (out_data),
      .out_keep           (out_keep),
      .out_last           (out_last),
      .out_valid          (out_valid),
      .out_credit         (out_credit)
   );

   initial
   begin
      rx_clk = 1'b0;
      forever #2 rx_clk = ~rx_clk;
   end

   task automatic report_mismatch(input string msg);
      begin
         $display("MISMATCH at %0t: %s", $time, msg);
         $display("Simulation failed");
         $fatal(1, "check failed");
      end
   endtask

   function automatic int rand_below(input int n);
      rand_below = int'($unsigned($random(seed)) % $unsigned(n));
   endfunction

   task automatic idle_cycles(input int n);
      begin
         tvalid  = 1'b0;
         tlast   = 1'b0;
         tuser   = 1'b0;
         tracked = 1'b0;
         repeat (n)
         begin
            @(posedge rx_clk);
            #1;
         end
      end
   endtask

   // one frame, a beat per cycle, tuser on the last beat for error frames
   task automatic send_frame(input int len, input logic err);
      int   i;
      logic keep_frame;
      begin
         // whole frame judged at its first beat
         keep_frame = (occ_pred <= int'(ROOM_LEVEL));
         if (!keep_frame)
            frames_dropped = frames_dropped + 1;
         for (i = 0; i < len; i = i + 1)
         begin
            tdata   = {$random(seed), $random(seed)};
            tlast   = (i == len - 1);
            tkeep   = tlast ? (8'hff >> rand_below(8)) : 8'hff;
            tuser   = tlast && err;
            tvalid  = 1'b1;
            tracked = keep_frame && !err;
            @(posedge rx_clk);
            #1;
         end
         idle_cycles(1);
      end
   endtask

   task automatic wait_drained;
      begin
         while (exp_q.size() != 0)
            @(posedge rx_clk);
         @(posedge rx_clk);
         #1;
      end
   endtask

   // credits go back one per cycle while enabled
   initial
   begin
      out_credit   = 1'b0;
      credits_sent = 0;
      forever
      begin
         @(posedge rx_clk);
         #1;
         if (!sys_rst && credit_on && (beats_out - credits_sent) > 0)
         begin
            out_credit   = 1'b1;
            credits_sent = credits_sent + 1;
         end
         else
            out_credit = 1'b0;
      end
   end

   // mid-cycle sampling of the bus and the DUT outputs
   always @(negedge rx_clk)
   begin
      if (sys_rst)
      begin
         assert (!out_valid && !pause_req)
            else report_mismatch("out_valid or pause_req high during reset");
         exp_q.delete();
         occ_pred     = 0;
         prev_pred    = 0;
         kept_d1      = 1'b0;
         kept_d2      = 1'b0;
         beats_out    = 0;
         credits_seen = 0;
         since_rst    = 0;
      end
      else
      begin
         if (since_rst < 2)
         begin
            assert (!out_valid) else report_mismatch("out_valid high right after reset");
            since_rst = since_rst + 1;
         end
         if (tvalid && tracked)
            exp_q.push_back({tlast, tkeep, tdata});
         // a beat shows in the queue count two samples after it is presented
         occ_pred = occ_pred + (kept_d2 ? 1 : 0);
         kept_d2  = kept_d1;
         kept_d1  = tvalid && tracked;
         if (out_valid)
         begin
            assert (exp_q.size() > 0) else report_mismatch("output beat with no frame expected");
            exp_beat = exp_q.pop_front();
            assert (out_data == exp_beat[63:0] && out_keep == exp_beat[71:64] &&
                    out_last == exp_beat[72])
               else report_mismatch($sformatf("beat %0d got %h/%h/%b expected %h/%h/%b",
                  beats_out, out_data, out_keep, out_last,
                  exp_beat[63:0], exp_beat[71:64], exp_beat[72]));
            beats_out = beats_out + 1;
            occ_pred  = occ_pred - 1;
         end
         // never more beats than credits owned
         assert (beats_out <= int'(CREDIT_MAX) + credits_seen)
            else report_mismatch($sformatf("%0d beats sent with %0d credits returned",
               beats_out, credits_seen));
         if (out_credit)
            credits_seen = credits_seen + 1;
         // pause follows the count one cycle late
         if (occ_pred >= int'(PAUSE_LEVEL) && prev_pred >= int'(PAUSE_LEVEL))
         begin
            assert (pause_req)
               else report_mismatch($sformatf("pause_req low at fill %0d", occ_pred));
         end
         if (occ_pred < int'(PAUSE_LEVEL) && prev_pred < int'(PAUSE_LEVEL))
         begin
            assert (!pause_req)
               else report_mismatch($sformatf("pause_req high at fill %0d", occ_pred));
         end
         prev_pred = occ_pred;
      end
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge rx_clk);
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      seed           = 40624;
      frames_dropped = 0;
      credit_on      = 1'b0;
      tdata          = '0;
      tkeep          = '0;
      tlast          = 1'b0;
      tuser          = 1'b0;
      tvalid         = 1'b0;
      tracked        = 1'b0;
      sys_rst        = 1'b1;
      repeat (3) @(posedge rx_clk);
      #1;
      sys_rst = 1'b0;
      idle_cycles(4);
      // good frames with prompt credits
      credit_on = 1'b1;
      repeat (N_PASS)
      begin
         send_frame(1 + rand_below(16), 1'b0);
         idle_cycles(rand_below(3));
      end
      wait_drained();
      // error frames mixed in
      repeat (N_ERR)
      begin
         send_frame(1 + rand_below(16), rand_below(3) == 0);
         idle_cycles(rand_below(3));
      end
      wait_drained();
      // let a trailing error frame drain
      idle_cycles(40);
      // credits withheld until the queue overflows
      credit_on = 1'b0;
      repeat (N_FULL)
      begin
         send_frame(8 + rand_below(9), 1'b0);
         idle_cycles(12);
      end
      assert (frames_dropped > 0)
      else
      begin
         $display("no frame was dropped while credits were withheld");
         $display("Simulation failed");
         $fatal(1, "queue never reached the drop level");
      end
      credit_on = 1'b1;
      wait_drained();
      idle_cycles(10);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* design/rx_ingress_top.sv */
// rx ingress top level joining frame writer, frame buffer and frame reader
`timescale 1ns/1ps
`default_nettype none

module rx_ingress_top
   import rx_ingress_pkg::*;
(
   input  logic       rx_clk,
   input  logic       sys_rst,
   input  beat_data_t rx_axis_mac_tdata,
   input  beat_keep_t rx_axis_mac_tkeep,
   input  logic       rx_axis_mac_tlast,
   input  logic       rx_axis_mac_tuser,
   input  logic       rx_axis_mac_tvalid,
   output logic       pause_req,
   output beat_data_t out_data,
   output beat_keep_t out_keep,
   output logic       out_last,
   output logic       out_valid,
   input  logic       out_credit
);

   // writer side of the queues
   data_entry_t   data_wdata;
   logic          data_wren;
   frame_status_t status_wdata;
   logic          status_wren;
   data_count_t   data_count;
   logic          status_full;
   // reader side of the queues
   data_entry_t   data_rdata;
   logic          data_rden;
   logic          data_empty;
   frame_status_t status_rdata;
   logic          status_rden;
   logic          status_empty;

   rx_frame_writer writer0 (
      .rx_clk             (rx_clk),
      .sys_rst            (sys_rst),
      .rx_axis_mac_tdata  (rx_axis_mac_tdata),
      .rx_axis_mac_tkeep  (rx_axis_mac_tkeep),
      .rx_axis_mac_tlast  (rx_axis_mac_tlast),
      .rx_axis_mac_tuser  (rx_axis_mac_tuser),
      .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
      .data_count         (data_count),
      .status_full        (status_full),
      .data_wdata         (data_wdata),
      .data_wren          (data_wren),
      .status_wdata       (status_wdata),
      .status_wren        (status_wren),
      .pause_req          (pause_req)
   );

   rx_frame_buffer buffer0 (
      .rx_clk       (rx_clk),
      .sys_rst      (sys_rst),
      .data_wdata   (data_wdata),
      .data_wren    (data_wren),
      .data_rden    (data_rden),
      .data_rdata   (data_rdata),
      .data_empty   (data_empty),
      .data_count   (data_count),
      .status_wdata (status_wdata),
      .status_wren  (status_wren),
      .status_rden  (status_rden),
      .status_rdata (status_rdata),
      .status_empty (status_empty),
      .status_full  (status_full)
   );

   rx_frame_reader reader0 (
      .rx_clk       (rx_clk),
      .sys_rst      (sys_rst),
      .data_rdata   (data_rdata),
      .data_empty   (data_empty),
      .data_rden    (data_rden),
      .status_rdata (status_rdata),
      .status_empty (status_empty),
      .status_rden  (status_rden),
      .out_data     (out_data),
      .out_keep     (out_keep),
      .out_last     (out_last),
      .out_valid    (out_valid),
      .out_credit   (out_credit)
   );

endmodule

`default_nettype wire

/* design/rx_frame_reader.sv */
// frame reader driven by status entries, error-frame discard and credit-counted output
`timescale 1ns/1ps
`default_nettype none

module rx_frame_reader
   import rx_ingress_pkg::*;
(
   input  logic          rx_clk,
   input  logic          sys_rst,
   input  data_entry_t   data_rdata,
   input  logic          data_empty,
   output logic          data_rden,
   input  frame_status_t status_rdata,
   input  logic          status_empty,
   output logic          status_rden,
   output beat_data_t    out_data,
   output beat_keep_t    out_keep,
   output logic          out_last,
   output logic          out_valid,
   input  logic          out_credit
);

   reader_state_t state;
   reader_state_t state_nxt;
   credit_count_t credit;
   // head beat goes out this cycle
   logic          beat_go;
   // head beat of an error frame is thrown away
   logic          beat_drop;
   logic          head_last;

   assign head_last = data_rdata[72];

   // good frame needs data and a credit
   assign beat_go   = (state == rd_send) && !data_empty && (credit != '0);
   // error frame drains at full rate
   assign beat_drop = (state == rd_discard) && !data_empty;

   // status popped as the frame begins
   assign status_rden = (state == rd_idle) && !status_empty;
   assign data_rden   = beat_go || beat_drop;

   always_comb
   begin
      state_nxt = state;
      case (state)
         rd_idle:
            if (!status_empty)
            begin
               state_nxt = status_rdata[STATUS_ERR_BIT] ? rd_discard : rd_send;
            end
         rd_send:
            if (beat_go && head_last)
            begin
               state_nxt = rd_idle;
            end
         rd_discard:
            if (beat_drop && head_last)
            begin
               state_nxt = rd_idle;
            end
         default:
            state_nxt = rd_idle;
      endcase
   end

   always_ff @(posedge rx_clk or posedge sys_rst)
   begin
      if (sys_rst)
      begin
         state     <= rd_idle;
         credit    <= CREDIT_MAX;
         out_valid <= 1'b0;
      end
      else
      begin
         state     <= state_nxt;
         out_valid <= beat_go;
         // returned credit and spent credit may meet on one edge
         case ({out_credit, beat_go})
            2'b10:   credit <= credit + credit_count_t'(1);
            2'b01:   credit <= credit - credit_count_t'(1);
            default: credit <= credit;
         endcase
      end
   end

   // output beat captured from the head entry
   always_ff @(posedge rx_clk)
   begin
      if (beat_go)
      begin
         out_data <= data_rdata[63:0];
         out_keep <= data_rdata[71:64];
         out_last <= head_last;
      end
   end

endmodule

`default_nettype wire

/* design/rx_frame_buffer.sv */
// data and status queues, first-word-fall-through, with data fill count
`timescale 1ns/1ps
`default_nettype none

module rx_frame_buffer
   import rx_ingress_pkg::*;
(
   input  logic          rx_clk,
   input  logic          sys_rst,
   input  data_entry_t   data_wdata,
   input  logic          data_wren,
   input  logic          data_rden,
   output data_entry_t   data_rdata,
   output logic          data_empty,
   output data_count_t   data_count,
   input  frame_status_t status_wdata,
   input  logic          status_wren,
   input  logic          status_rden,
   output frame_status_t status_rdata,
   output logic          status_empty,
   output logic          status_full
);

   localparam int DATA_AW   = $clog2(DATA_DEPTH);
   localparam int STATUS_AW = $clog2(STATUS_DEPTH);

   // beat storage
   data_entry_t          data_mem [DATA_DEPTH];
   logic [DATA_AW-1:0]   data_wptr;
   logic [DATA_AW-1:0]   data_rptr;
   logic                 data_push;
   logic                 data_pop;
   // status storage
   frame_status_t        status_mem [STATUS_DEPTH];
   logic [STATUS_AW-1:0] status_wptr;
   logic [STATUS_AW-1:0] status_rptr;
   logic [STATUS_AW:0]   status_count;
   logic                 status_push;
   logic                 status_pop;

   // head entry straight from the array
   assign data_rdata   = data_mem[data_rptr];
   assign status_rdata = status_mem[status_rptr];

   assign data_empty   = (data_count == '0);
   assign status_empty = (status_count == '0);
   assign status_full  = (status_count == (STATUS_AW+1)'(STATUS_DEPTH));

   // overflow and underflow guarded here as well
   assign data_push   = data_wren && (data_count != data_count_t'(DATA_DEPTH));
   assign data_pop    = data_rden && !data_empty;
   assign status_push = status_wren && !status_full;
   assign status_pop  = status_rden && !status_empty;

   always_ff @(posedge rx_clk)
   begin
      if (data_push)
      begin
         data_mem[data_wptr] <= data_wdata;
      end
      if (status_push)
      begin
         status_mem[status_wptr] <= status_wdata;
      end
   end

   always_ff @(posedge rx_clk or posedge sys_rst)
   begin
      if (sys_rst)
      begin
         data_wptr    <= '0;
         data_rptr    <= '0;
         data_count   <= '0;
         status_wptr  <= '0;
         status_rptr  <= '0;
         status_count <= '0;
      end
      else
      begin
         // pointers wrap on their own width
         if (data_push)
            data_wptr <= data_wptr + DATA_AW'(1);
         if (data_pop)
            data_rptr <= data_rptr + DATA_AW'(1);
         // push and pop together leave the count alone
         case ({data_push, data_pop})
            2'b10:   data_count <= data_count + data_count_t'(1);
            2'b01:   data_count <= data_count - data_count_t'(1);
            default: data_count <= data_count;
         endcase
         if (status_push)
            status_wptr <= status_wptr + STATUS_AW'(1);
         if (status_pop)
            status_rptr <= status_rptr + STATUS_AW'(1);
         case ({status_push, status_pop})
            2'b10:   status_count <= status_count + (STATUS_AW+1)'(1);
            2'b01:   status_count <= status_count - (STATUS_AW+1)'(1);
            default: status_count <= status_count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/rx_frame_writer.sv */
// frame writer with per-frame keep or drop decision, registered queue writes and pause request
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer
   import rx_ingress_pkg::*;
(
   input  logic          rx_clk,
   input  logic          sys_rst,
   input  beat_data_t    rx_axis_mac_tdata,
   input  beat_keep_t    rx_axis_mac_tkeep,
   input  logic          rx_axis_mac_tlast,
   input  logic          rx_axis_mac_tuser,
   input  logic          rx_axis_mac_tvalid,
   input  data_count_t   data_count,
   input  logic          status_full,
   output data_entry_t   data_wdata,
   output logic          data_wren,
   output frame_status_t status_wdata,
   output logic          status_wren,
   output logic          pause_req
);

   writer_state_t state;
   writer_state_t state_nxt;
   // fill count plus a beat still on its way into the queue
   logic [7:0]    fill_now;
   logic          keep_ok;
   logic          beat_keep;

   // last beat of the previous frame may still be in flight
   assign fill_now = {1'b0, data_count} + {7'b0, data_wren};

   // room for a maximum-length frame and a free status slot
   // status_full is settled here since the mac leaves a gap between frames
   assign keep_ok = (fill_now <= {1'b0, ROOM_LEVEL}) && !status_full;

   // beat belongs to a kept frame
   // first beat decides on the spot, later beats follow the state
   assign beat_keep = rx_axis_mac_tvalid &&
                      ((state == wr_idle && keep_ok) || state == wr_pass);

   always_comb
   begin
      state_nxt = state;
      case (state)
         wr_idle:
            // single-beat frame stays in idle
            if (rx_axis_mac_tvalid && !rx_axis_mac_tlast)
            begin
               state_nxt = keep_ok ? wr_pass : wr_drop;
            end
         wr_pass,
         wr_drop:
            // a started frame always runs to its last beat
            if (rx_axis_mac_tvalid && rx_axis_mac_tlast)
            begin
               state_nxt = wr_idle;
            end
         default:
            state_nxt = wr_idle;
      endcase
   end

   always_ff @(posedge rx_clk or posedge sys_rst)
   begin
      if (sys_rst)
      begin
         state       <= wr_idle;
         data_wren   <= 1'b0;
         status_wren <= 1'b0;
         pause_req   <= 1'b0;
      end
      else
      begin
         state       <= state_nxt;
         // write one cycle after the beat
         data_wren   <= beat_keep;
         // status lands with the last beat
         status_wren <= beat_keep && rx_axis_mac_tlast;
         // one cycle behind the count
         pause_req   <= (data_count >= PAUSE_LEVEL);
      end
   end

   // payload follows the stream every cycle
   // only the enables decide what is stored
   always_ff @(posedge rx_clk)
   begin
      data_wdata                   <= {rx_axis_mac_tlast, rx_axis_mac_tkeep, rx_axis_mac_tdata};
      status_wdata                 <= '0;
      // tuser only means something on the last beat
      status_wdata[STATUS_ERR_BIT] <= rx_axis_mac_tuser;
   end

endmodule

`default_nettype wire

/* design/rx_ingress_pkg.sv */
// queue depths, fill thresholds, word types and fsm encodings of the rx ingress path
`default_nettype none

package rx_ingress_pkg;

   // queue geometry
   localparam int DATA_DEPTH      = 64;
   localparam int STATUS_DEPTH    = 8;
   // longest frame the mac will hand over
   localparam int MAX_FRAME_BEATS = 16;

   // one beat of the mac stream
   typedef logic [63:0] beat_data_t;
   typedef logic [7:0]  beat_keep_t;
   // data queue word holding last, keep and data from the top down
   typedef logic [72:0] data_entry_t;
   // per-frame status byte
   typedef logic [7:0]  frame_status_t;
   // fill count runs 0 to 64 inclusive
   typedef logic [6:0]  data_count_t;
   // credits held by the reader, 0 to 4
   typedef logic [2:0]  credit_count_t;

   // first beat must find room for a full-length frame
   localparam data_count_t ROOM_LEVEL  = data_count_t'(DATA_DEPTH - MAX_FRAME_BEATS);
   // half full
   localparam data_count_t PAUSE_LEVEL = 7'd32;
   // pause length agreed with the mac side
   localparam int PAUSE_QUANTA = 128;
   localparam credit_count_t CREDIT_MAX = 3'd4;
   // mac error flag inside the status byte
   localparam int STATUS_ERR_BIT = 0;

   // writer fsm
   typedef enum logic [1:0] {wr_idle, wr_pass, wr_drop} writer_state_t;
   // reader fsm
   typedef enum logic [1:0] {rd_idle, rd_send, rd_discard} reader_state_t;

endpackage

`default_nettype wire
